//--- design/xdma_macros.svh
// XDMA mailbox constants
`ifndef XDMA_MACROS_SVH
`define XDMA_MACROS_SVH

// --------------------
// Widths
// --------------------
`define XDMA_ADDR_W 48
// Upper address bits naming the chip
`define XDMA_CHIP_ID_W 8
`define XDMA_ID_W 8
`define XDMA_FRAME_LEN_W 8
`define XDMA_LEN_W 16
`define XDMA_NARROW_DW 64
// Narrow beats per wide cfg frame
`define XDMA_WIDE_NARROW_RATIO 8

// --------------------
// Address map
// --------------------
`define XDMA_CLUSTER_SPACE 48'h0000_0010_0000
// Main memory bounds, below the chip id bits
`define XDMA_MAIN_MEM_BASE 48'h0000_8000_0000
`define XDMA_MAIN_MEM_END 48'h0001_0000_0000
// One mailbox window in bytes
`define XDMA_WIN_SIZE 4096

// Queue depths
`define XDMA_DESC_DEPTH 2
`define XDMA_GRANT_DEPTH 3

`endif

//--- design/xdma_pkg.sv
// XDMA shared types
`include "xdma_macros.svh"

package xdma_pkg;

  // Window index, counted down from the end address
  typedef enum logic [1:0] {
    WIN_FINISH = 2'd0,
    WIN_GRANT  = 2'd1,
    WIN_CFG    = 2'd2,
    WIN_DATA   = 2'd3
  } xdma_win_e;

  // Header tracking for multi-frame tasks
  typedef enum logic {
    HDR_IDLE = 1'b0,
    HDR_BODY = 1'b1
  } xdma_hdr_state_e;

  // Inbound narrow write class
  typedef enum logic [1:0] {
    RX_CFG    = 2'd0,
    RX_GRANT  = 2'd1,
    RX_FINISH = 2'd2,
    RX_DROP   = 2'd3
  } xdma_rx_kind_e;

  // Grant record as packed in the low 56 data bits
  typedef struct packed {
    logic [`XDMA_ID_W-1:0]   dma_id;
    logic [`XDMA_ADDR_W-1:0] from;
  } xdma_grant_t;

  // End of the cluster or main memory region holding addr
  function automatic logic [`XDMA_ADDR_W-1:0] xdma_remote_end_addr(
      input logic [`XDMA_ADDR_W-1:0] addr);
    logic [`XDMA_ADDR_W-1:0] mem_base;
    logic [`XDMA_ADDR_W-1:0] mem_end;
    logic [`XDMA_ADDR_W-1:0] cl_mask;
    mem_base = `XDMA_MAIN_MEM_BASE;
    mem_end  = `XDMA_MAIN_MEM_END;
    cl_mask  = ~(`XDMA_CLUSTER_SPACE - 1);
    // Chip id kept, lower bits compared against main memory
    if (addr[`XDMA_ADDR_W-`XDMA_CHIP_ID_W-1:0] >= mem_base[`XDMA_ADDR_W-`XDMA_CHIP_ID_W-1:0]) begin
      return {addr[`XDMA_ADDR_W-1:`XDMA_ADDR_W-`XDMA_CHIP_ID_W],
              mem_end[`XDMA_ADDR_W-`XDMA_CHIP_ID_W-1:0]};
    end
    return (addr & cl_mask) + `XDMA_CLUSTER_SPACE;
  endfunction

  // Start of a mailbox window below end_addr
  function automatic logic [`XDMA_ADDR_W-1:0] xdma_window_base(
      input logic [`XDMA_ADDR_W-1:0] end_addr, input xdma_win_e win);
    logic [`XDMA_ADDR_W-1:0] offset;
    offset = ({{(`XDMA_ADDR_W-2){1'b0}}, win} + 1) * `XDMA_WIN_SIZE;
    return end_addr - offset;
  endfunction

endpackage

//--- design/xdma_desc_if.sv
// Descriptor handoff interface
`timescale 1ns/1ps
`include "xdma_macros.svh"

interface xdma_desc_if;
  // Handshake
  logic                    valid;
  logic                    ready;
  // Decoded descriptor fields
  logic [`XDMA_ID_W-1:0]   dma_id;
  logic [`XDMA_ADDR_W-1:0] remote_addr;
  logic [`XDMA_LEN_W-1:0]  dma_len;

  // Sender decode side
  modport decode (
    output valid, dma_id, remote_addr, dma_len,
    input  ready
  );

  // Issue queue side
  modport issue (
    input  valid, dma_id, remote_addr, dma_len,
    output ready
  );

endinterface

//--- design/xdma_rx_if.sv
// Receiver grant and finish interface
`timescale 1ns/1ps
`include "xdma_macros.svh"

interface xdma_rx_if;
  // Grant push, valid/ready
  logic                                grant_valid;
  logic                                grant_ready;
  // Raw grant record, id over sender address
  logic [`XDMA_ID_W+`XDMA_ADDR_W-1:0]  grant;
  // One-cycle strobe, always taken
  logic                                finish;

  // Address router side
  modport router (
    output grant_valid, grant, finish,
    input  grant_ready
  );

  // Grant tracker side
  modport tracker (
    input  grant_valid, grant, finish,
    output grant_ready
  );

endinterface

//--- design/xdma_cfg_decode.sv
// Sender cfg frame decode
`timescale 1ns/1ps
`include "xdma_macros.svh"

module xdma_cfg_decode (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Cfg frame fields
  input  logic [`XDMA_ID_W-1:0]        cfg_dma_id_i,
  input  logic                         cfg_dma_type_i,
  input  logic [`XDMA_ADDR_W-1:0]      cfg_reader_addr_i,
  input  logic [`XDMA_ADDR_W-1:0]      cfg_writer_addr_i,
  input  logic [`XDMA_FRAME_LEN_W-1:0] cfg_frame_len_i,
  input  logic                         cfg_valid_i,
  output logic                         cfg_ready_o,
  // Decoded descriptor out
  xdma_desc_if.decode                  desc
);

  localparam int FrameW   = `XDMA_FRAME_LEN_W;
  localparam int LenShift = $clog2(`XDMA_WIDE_NARROW_RATIO);

  xdma_pkg::xdma_hdr_state_e state_q, state_d;
  logic [FrameW-1:0]         frame_cnt_q, frame_cnt_d;
  logic [FrameW-1:0]         frame_len_q, frame_len_d;
  logic [`XDMA_ADDR_W-1:0]   remote_sel;
  logic [`XDMA_ADDR_W-1:0]   remote_end;
  logic                      cfg_fire;

  // Body frames stall with the queue too
  assign cfg_ready_o = desc.ready;
  assign cfg_fire    = cfg_valid_i && cfg_ready_o;

  // --------------------
  // Descriptor fields
  // --------------------
  // Read task targets the reader, write task the writer
  assign remote_sel = cfg_dma_type_i ? cfg_writer_addr_i : cfg_reader_addr_i;
  assign remote_end = xdma_pkg::xdma_remote_end_addr(remote_sel);

  assign desc.dma_id      = cfg_dma_id_i;
  // Remote cfg mailbox sits 12 KB below the region end
  assign desc.remote_addr = xdma_pkg::xdma_window_base(remote_end, xdma_pkg::WIN_CFG);
  // Cfg goes out as narrow beats, so scale by the width ratio
  assign desc.dma_len     = `XDMA_LEN_W'(cfg_frame_len_i) << LenShift;

  // --------------------
  // Header FSM
  // --------------------
  always_comb begin : proc_hdr_fsm
    state_d     = state_q;
    frame_cnt_d = frame_cnt_q;
    frame_len_d = frame_len_q;
    desc.valid  = 1'b0;
    case (state_q)
      xdma_pkg::HDR_IDLE: begin
        // Every frame seen here is a header
        desc.valid = cfg_valid_i;
        if (cfg_fire && (cfg_frame_len_i > FrameW'(1))) begin
          // Header counts as the first frame
          frame_len_d = cfg_frame_len_i;
          frame_cnt_d = FrameW'(1);
          state_d     = xdma_pkg::HDR_BODY;
        end
      end
      xdma_pkg::HDR_BODY: begin
        // Body frames are swallowed
        if (cfg_fire) begin
          if (frame_cnt_q == frame_len_q - 1'b1) begin
            frame_cnt_d = '0;
            state_d     = xdma_pkg::HDR_IDLE;
          end else begin
            frame_cnt_d = frame_cnt_q + 1'b1;
          end
        end
      end
      default: begin
        state_d = xdma_pkg::HDR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= xdma_pkg::HDR_IDLE;
      frame_cnt_q <= '0;
      frame_len_q <= '0;
    end else begin
      state_q     <= state_d;
      frame_cnt_q <= frame_cnt_d;
      frame_len_q <= frame_len_d;
    end
  end

endmodule

//--- design/xdma_desc_issue.sv
// Descriptor issue queue
`timescale 1ns/1ps
`include "xdma_macros.svh"

module xdma_desc_issue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  xdma_desc_if.issue              desc,
  // Outgoing descriptor
  output logic [`XDMA_ID_W-1:0]   desc_dma_id_o,
  output logic [`XDMA_ADDR_W-1:0] desc_remote_addr_o,
  output logic [`XDMA_LEN_W-1:0]  desc_dma_len_o,
  output logic                    desc_valid_o,
  input  logic                    desc_ready_i
);

  localparam int Depth = `XDMA_DESC_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  // Payload storage
  logic [`XDMA_ID_W-1:0]   id_mem   [Depth];
  logic [`XDMA_ADDR_W-1:0] addr_mem [Depth];
  logic [`XDMA_LEN_W-1:0]  len_mem  [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push, pop;

  assign desc.ready   = (count_q < CntW'(Depth));
  assign desc_valid_o = (count_q != '0);
  assign push = desc.valid && desc.ready;
  assign pop  = desc_valid_o && desc_ready_i;

  // Oldest entry on the outputs
  assign desc_dma_id_o      = id_mem[rd_ptr_q];
  assign desc_remote_addr_o = addr_mem[rd_ptr_q];
  assign desc_dma_len_o     = len_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q]   <= desc.dma_id;
      addr_mem[wr_ptr_q] <= desc.remote_addr;
      len_mem[wr_ptr_q]  <= desc.dma_len;
    end
  end

  // Pointers wrap at the last slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- design/xdma_rx_decode.sv
// Receiver mailbox window router
`timescale 1ns/1ps
`include "xdma_macros.svh"

module xdma_rx_decode (
  input  logic [`XDMA_ADDR_W-1:0]   cluster_base_addr_i,
  // Inbound narrow write
  input  logic [`XDMA_ADDR_W-1:0]   rx_addr_i,
  input  logic [`XDMA_NARROW_DW-1:0] rx_data_i,
  input  logic                      rx_valid_i,
  output logic                      rx_ready_o,
  // Cfg pass-through
  output logic [`XDMA_NARROW_DW-1:0] from_remote_cfg_o,
  output logic                      from_remote_cfg_valid_o,
  input  logic                      from_remote_cfg_ready_i,
  xdma_rx_if.router                 rx
);

  logic [`XDMA_ADDR_W-1:0] local_end;
  xdma_pkg::xdma_rx_kind_e rx_kind;

  // True when addr lies in the 4 KB window
  function automatic logic win_hit(input logic [`XDMA_ADDR_W-1:0] end_addr,
                                   input logic [`XDMA_ADDR_W-1:0] addr,
                                   input xdma_pkg::xdma_win_e     win);
    logic [`XDMA_ADDR_W-1:0] base;
    base = xdma_pkg::xdma_window_base(end_addr, win);
    return (addr >= base) && (addr < base + `XDMA_WIN_SIZE);
  endfunction

  // Mailboxes sit at the top of our own region
  assign local_end = xdma_pkg::xdma_remote_end_addr(cluster_base_addr_i);

  // --------------------
  // Classify
  // --------------------
  always_comb begin : proc_classify
    rx_kind = xdma_pkg::RX_DROP;
    if (win_hit(local_end, rx_addr_i, xdma_pkg::WIN_CFG)) begin
      rx_kind = xdma_pkg::RX_CFG;
    end else if (win_hit(local_end, rx_addr_i, xdma_pkg::WIN_GRANT)) begin
      rx_kind = xdma_pkg::RX_GRANT;
    end else if (win_hit(local_end, rx_addr_i, xdma_pkg::WIN_FINISH)) begin
      rx_kind = xdma_pkg::RX_FINISH;
    end
    // Data window and unmapped writes stay RX_DROP
  end

  // --------------------
  // Route
  // --------------------
  assign from_remote_cfg_o       = rx_data_i;
  assign from_remote_cfg_valid_o = rx_valid_i && (rx_kind == xdma_pkg::RX_CFG);

  // Grant record taken from the low data bits
  assign rx.grant       = rx_data_i[$bits(xdma_pkg::xdma_grant_t)-1:0];
  assign rx.grant_valid = rx_valid_i && (rx_kind == xdma_pkg::RX_GRANT);
  assign rx.finish      = rx_valid_i && (rx_kind == xdma_pkg::RX_FINISH);

  // Ready from the selected consumer
  always_comb begin : proc_ready_mux
    case (rx_kind)
      xdma_pkg::RX_CFG:   rx_ready_o = from_remote_cfg_ready_i;
      xdma_pkg::RX_GRANT: rx_ready_o = rx.grant_ready;
      // Finish strobe and drops never stall
      default:            rx_ready_o = 1'b1;
    endcase
  end

endmodule

//--- design/xdma_grant_tracker.sv
// Grant queue and finish pulse
`timescale 1ns/1ps
`include "xdma_macros.svh"

module xdma_grant_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  xdma_rx_if.tracker            rx,
  // Grant level and head task id
  output logic                  grant_o,
  output logic [`XDMA_ID_W-1:0] grant_dma_id_o,
  output logic                  xdma_finish_o
);

  localparam int Depth = `XDMA_GRANT_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  // Record storage
  xdma_pkg::xdma_grant_t grant_mem [Depth];
  xdma_pkg::xdma_grant_t head;

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            finish_q;
  logic            push, pop;

  assign rx.grant_ready = (count_q != CntW'(Depth));
  assign push = rx.grant_valid && rx.grant_ready;
  // Finish pulse retires the oldest grant
  assign pop  = finish_q && (count_q != '0);

  assign head           = grant_mem[rd_ptr_q];
  assign grant_o        = (count_q != '0);
  assign grant_dma_id_o = head.dma_id;
  assign xdma_finish_o  = finish_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      grant_mem[wr_ptr_q] <= xdma_pkg::xdma_grant_t'(rx.grant);
    end
  end

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      finish_q <= 1'b0;
    end else begin
      // Strobe delayed by one cycle
      finish_q <= rx.finish;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- design/xdma_mailbox_top.sv
// XDMA mailbox adapter top
`timescale 1ns/1ps
`include "xdma_macros.svh"

module xdma_mailbox_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [`XDMA_ADDR_W-1:0]      cluster_base_addr_i,
  // Sender cfg frames
  input  logic [`XDMA_ID_W-1:0]        cfg_dma_id_i,
  input  logic                         cfg_dma_type_i,
  input  logic [`XDMA_ADDR_W-1:0]      cfg_reader_addr_i,
  input  logic [`XDMA_ADDR_W-1:0]      cfg_writer_addr_i,
  input  logic [`XDMA_FRAME_LEN_W-1:0] cfg_frame_len_i,
  input  logic                         cfg_valid_i,
  output logic                         cfg_ready_o,
  // Outgoing descriptors
  output logic [`XDMA_ID_W-1:0]        desc_dma_id_o,
  output logic [`XDMA_ADDR_W-1:0]      desc_remote_addr_o,
  output logic [`XDMA_LEN_W-1:0]       desc_dma_len_o,
  output logic                         desc_valid_o,
  input  logic                         desc_ready_i,
  // Inbound narrow writes
  input  logic [`XDMA_ADDR_W-1:0]      rx_addr_i,
  input  logic [`XDMA_NARROW_DW-1:0]   rx_data_i,
  input  logic                         rx_valid_i,
  output logic                         rx_ready_o,
  // Cfg pass-through
  output logic [`XDMA_NARROW_DW-1:0]   from_remote_cfg_o,
  output logic                         from_remote_cfg_valid_o,
  input  logic                         from_remote_cfg_ready_i,
  // Grant and finish
  output logic                         grant_o,
  output logic [`XDMA_ID_W-1:0]        grant_dma_id_o,
  output logic                         xdma_finish_o
);

  xdma_desc_if desc_bus ();
  xdma_rx_if   rx_bus ();

  // --------------------
  // Sender path
  // --------------------
  xdma_cfg_decode u_cfg_decode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_dma_id_i      (cfg_dma_id_i),
    .cfg_dma_type_i    (cfg_dma_type_i),
    .cfg_reader_addr_i (cfg_reader_addr_i),
    .cfg_writer_addr_i (cfg_writer_addr_i),
    .cfg_frame_len_i   (cfg_frame_len_i),
    .cfg_valid_i       (cfg_valid_i),
    .cfg_ready_o       (cfg_ready_o),
    .desc              (desc_bus.decode)
  );

  xdma_desc_issue u_desc_issue (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .desc               (desc_bus.issue),
    .desc_dma_id_o      (desc_dma_id_o),
    .desc_remote_addr_o (desc_remote_addr_o),
    .desc_dma_len_o     (desc_dma_len_o),
    .desc_valid_o       (desc_valid_o),
    .desc_ready_i       (desc_ready_i)
  );

  // --------------------
  // Receiver path
  // --------------------
  xdma_rx_decode u_rx_decode (
    .cluster_base_addr_i     (cluster_base_addr_i),
    .rx_addr_i               (rx_addr_i),
    .rx_data_i               (rx_data_i),
    .rx_valid_i              (rx_valid_i),
    .rx_ready_o              (rx_ready_o),
    .from_remote_cfg_o       (from_remote_cfg_o),
    .from_remote_cfg_valid_o (from_remote_cfg_valid_o),
    .from_remote_cfg_ready_i (from_remote_cfg_ready_i),
    .rx                      (rx_bus.router)
  );

  xdma_grant_tracker u_grant_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rx             (rx_bus.tracker),
    .grant_o        (grant_o),
    .grant_dma_id_o (grant_dma_id_o),
    .xdma_finish_o  (xdma_finish_o)
  );

endmodule

//--- verif/xdma_tb_vectors.svh
// Mailbox testbench vectors
`ifndef XDMA_TB_VECTORS_SVH
`define XDMA_TB_VECTORS_SVH

// Row operations
localparam logic [1:0] OP_TASK = 2'd0;
localparam logic [1:0] OP_BODY = 2'd1;
localparam logic [1:0] OP_RX   = 2'd2;
localparam logic [1:0] OP_HOLD = 2'd3;

// One table row with inputs first and expected values after
typedef struct packed {
  logic [1:0]  op;
  logic [7:0]  id;
  logic        dtype;
  logic [47:0] raddr;
  logic [47:0] waddr;
  logic [7:0]  flen;
  logic [47:0] rx_addr;
  logic [63:0] rx_data;
  // desc_ready_i on hold rows and from_remote_cfg_ready_i on rx rows
  logic        knob;
  logic [47:0] exp_addr;
  logic [15:0] exp_len;
  logic        exp_ready;
  logic        exp_cfg_valid;
  logic        exp_finish;
  logic        exp_grant;
  logic [7:0]  exp_gid;
} vec_row_t;

vec_row_t rows[$];

// Top of the cluster or main memory region holding a
function automatic logic [47:0] region_end(input logic [47:0] a);
  if (a[39:0] >= 40'h00_8000_0000) begin
    return {a[47:40], 40'h01_0000_0000};
  end
  return {a[47:20], 20'h0} + 48'h10_0000;
endfunction

function automatic vec_row_t frame_row(input logic [1:0] op, input logic [7:0] id,
                                       input logic dtype, input logic [47:0] raddr,
                                       input logic [47:0] waddr, input logic [7:0] flen);
  vec_row_t r;
  r       = '0;
  r.op    = op;
  r.id    = id;
  r.dtype = dtype;
  r.raddr = raddr;
  r.waddr = waddr;
  r.flen  = flen;
  // Remote cfg mailbox is the third 4 KB slot below the top
  r.exp_addr = region_end(dtype ? waddr : raddr) - 48'h3000;
  // Eight narrow beats per frame
  r.exp_len  = {5'd0, flen, 3'd0};
  return r;
endfunction

function automatic vec_row_t rx_row(input logic [47:0] addr, input logic [63:0] data,
                                    input logic cfg_rdy, input logic rdy, input logic cfg_vld,
                                    input logic fin, input logic gnt, input logic [7:0] gid);
  vec_row_t r;
  r               = '0;
  r.op            = OP_RX;
  r.rx_addr       = addr;
  r.rx_data       = data;
  r.knob          = cfg_rdy;
  r.exp_ready     = rdy;
  r.exp_cfg_valid = cfg_vld;
  r.exp_finish    = fin;
  r.exp_grant     = gnt;
  r.exp_gid       = gid;
  return r;
endfunction

function automatic vec_row_t hold_row(input logic rdy, input logic exp_cfg_ready);
  vec_row_t r;
  r           = '0;
  r.op        = OP_HOLD;
  r.knob      = rdy;
  r.exp_ready = exp_cfg_ready;
  return r;
endfunction

function automatic logic [7:0] rand_id();
  logic [31:0] rnd;
  rnd = $random(seed);
  return rnd[7:0];
endfunction

// Somewhere inside a cluster below main memory
function automatic logic [47:0] rand_cluster_addr();
  logic [31:0] rnd;
  rnd = $random(seed);
  return {16'h0000, 4'h1, rnd[27:3], 3'b000};
endfunction

// Main memory of a random chip
function automatic logic [47:0] rand_mem_addr();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = $random(seed);
  lo = $random(seed);
  return {hi[7:0], 8'h00, 1'b1, lo[30:0]};
endfunction

task automatic build_table();
  logic [47:0] lend;
  logic [47:0] a;
  logic [7:0]  id;
  logic [31:0] rnd;
  logic [63:0] data;
  logic [7:0]  gid [3];
  lend = region_end(ClusterBase);
  rows.push_back(hold_row(1'b1, 1'b1));
  // --------------------
  // Sender side
  // --------------------
  id = rand_id();
  a  = rand_cluster_addr();
  rows.push_back(frame_row(OP_TASK, id, 1'b0, a, 48'h0, 8'd1));
  // Write into main memory of some chip with one body frame
  id = rand_id();
  a  = rand_mem_addr();
  rows.push_back(frame_row(OP_TASK, id, 1'b1, 48'h0, a, 8'd2));
  rows.push_back(frame_row(OP_BODY, id + 8'd1, 1'b1, 48'h0, a, 8'd2));
  // Four frames give one descriptor
  id = rand_id();
  a  = rand_cluster_addr();
  rows.push_back(frame_row(OP_TASK, id, 1'b0, a, 48'h0, 8'd4));
  for (int i = 0; i < 3; i++) begin
    rows.push_back(frame_row(OP_BODY, id + 8'(i + 1), 1'b0, a, 48'h0, 8'd4));
  end
  id = rand_id();
  a  = rand_cluster_addr();
  rows.push_back(frame_row(OP_TASK, id, 1'b1, 48'h0, a, 8'd1));
  // Two headers fill the queue under back-pressure
  rows.push_back(hold_row(1'b0, 1'b1));
  id = rand_id();
  a  = rand_cluster_addr();
  rows.push_back(frame_row(OP_TASK, id, 1'b0, a, 48'h0, 8'd1));
  id = rand_id();
  a  = rand_mem_addr();
  rows.push_back(frame_row(OP_TASK, id, 1'b1, 48'h0, a, 8'd1));
  rows.push_back(hold_row(1'b0, 1'b0));
  rows.push_back(hold_row(1'b1, 1'b0));
  rows.push_back(hold_row(1'b1, 1'b1));
  // --------------------
  // Receiver side
  // --------------------
  rnd  = $random(seed);
  data = {rnd, ~rnd};
  a    = lend - 48'h3000 + {36'h0, rnd[11:3], 3'b000};
  // Cfg write stalls on the consumer and then passes
  rows.push_back(rx_row(a, data, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'h0));
  rows.push_back(rx_row(a, data, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'h0));
  // Data window and then the next cluster up, cfg consumer stalled
  rows.push_back(rx_row(lend - 48'h4000 + 48'h40, data, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h0));
  rows.push_back(rx_row(lend + 48'h2000, data, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h0));
  // Distinct ids in the low two bits
  for (int i = 0; i < 3; i++) begin
    rnd    = $random(seed);
    gid[i] = {rnd[7:2], 2'(i)};
    a      = rand_cluster_addr();
    data   = {8'h00, gid[i], a};
    rows.push_back(rx_row(lend - 48'h2000 + 48'(8 * i), data, 1'b1, 1'b1, 1'b0, 1'b0,
                          1'b1, gid[0]));
  end
  // Queue full
  rows.push_back(rx_row(lend - 48'h2000, data, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, gid[0]));
  rows.push_back(rx_row(lend - 48'h1000, 64'h1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, gid[1]));
  rows.push_back(rx_row(lend - 48'h1000, 64'h2, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, gid[2]));
  rows.push_back(rx_row(lend - 48'h1000, 64'h3, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 8'h0));
endtask

`endif

//--- verif/xdma_mailbox_tb.sv
// XDMA mailbox testbench
`timescale 1ns/1ps
`include "xdma_macros.svh"

module xdma_mailbox_tb;

  localparam int          ResetCycles = 16;
  localparam logic [47:0] ClusterBase = 48'h0000_1030_0000;

  logic        clk_i;
  logic        rst_ni;
  logic [47:0] cluster_base_addr_i;
  logic [7:0]  cfg_dma_id_i;
  logic        cfg_dma_type_i;
  logic [47:0] cfg_reader_addr_i;
  logic [47:0] cfg_writer_addr_i;
  logic [7:0]  cfg_frame_len_i;
  logic        cfg_valid_i;
  logic        cfg_ready_o;
  logic [7:0]  desc_dma_id_o;
  logic [47:0] desc_remote_addr_o;
  logic [15:0] desc_dma_len_o;
  logic        desc_valid_o;
  logic        desc_ready_i;
  logic [47:0] rx_addr_i;
  logic [63:0] rx_data_i;
  logic        rx_valid_i;
  logic        rx_ready_o;
  logic [63:0] from_remote_cfg_o;
  logic        from_remote_cfg_valid_o;
  logic        from_remote_cfg_ready_i;
  logic        grant_o;
  logic [7:0]  grant_dma_id_o;
  logic        xdma_finish_o;

  int seed;
  int errors;
  int cycle_cnt;
  int cycle_limit;
  // Pending descriptors as {id, addr, len}
  logic [71:0] exp_desc_q[$];

  `include "xdma_tb_vectors.svh"

  xdma_mailbox_top u_xdma_mailbox_top (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  task automatic report_error(input string what, input logic [63:0] got,
                              input logic [63:0] want);
    errors++;
    $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
  endtask

  // --------------------
  // Row drivers
  // --------------------
  task automatic run_cfg_row(input vec_row_t r);
    logic ready_seen;
    cfg_dma_id_i      = r.id;
    cfg_dma_type_i    = r.dtype;
    cfg_reader_addr_i = r.raddr;
    cfg_writer_addr_i = r.waddr;
    cfg_frame_len_i   = r.flen;
    cfg_valid_i       = 1'b1;
    // Frame moves on the edge after a high ready
    do begin
      @(negedge clk_i);
      ready_seen = cfg_ready_o;
      @(posedge clk_i);
      #1;
    end while (!ready_seen);
    cfg_valid_i = 1'b0;
    if (r.op == OP_TASK) begin
      exp_desc_q.push_back({r.id, r.exp_addr, r.exp_len});
      @(negedge clk_i);
      // One cycle latency
      if (desc_valid_o !== 1'b1) report_error("desc_valid_o", desc_valid_o, 1'b1);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_rx_row(input vec_row_t r);
    rx_addr_i               = r.rx_addr;
    rx_data_i               = r.rx_data;
    from_remote_cfg_ready_i = r.knob;
    rx_valid_i              = 1'b1;
    @(negedge clk_i);
    if (rx_ready_o !== r.exp_ready) report_error("rx_ready_o", rx_ready_o, r.exp_ready);
    if (from_remote_cfg_valid_o !== r.exp_cfg_valid) begin
      report_error("from_remote_cfg_valid_o", from_remote_cfg_valid_o, r.exp_cfg_valid);
    end
    if (r.exp_cfg_valid && from_remote_cfg_o !== r.rx_data) begin
      report_error("from_remote_cfg_o", from_remote_cfg_o, r.rx_data);
    end
    @(posedge clk_i);
    #1;
    rx_valid_i              = 1'b0;
    from_remote_cfg_ready_i = 1'b1;
    @(negedge clk_i);
    if (xdma_finish_o !== r.exp_finish) report_error("xdma_finish_o", xdma_finish_o, r.exp_finish);
    @(posedge clk_i);
    @(negedge clk_i);
    // Pulse gone and head retired
    if (xdma_finish_o !== 1'b0) report_error("xdma_finish_o late", xdma_finish_o, 1'b0);
    if (grant_o !== r.exp_grant) report_error("grant_o", grant_o, r.exp_grant);
    if (r.exp_grant && grant_dma_id_o !== r.exp_gid) begin
      report_error("grant_dma_id_o", grant_dma_id_o, r.exp_gid);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_hold_row(input vec_row_t r);
    desc_ready_i = r.knob;
    @(negedge clk_i);
    if (cfg_ready_o !== r.exp_ready) report_error("cfg_ready_o", cfg_ready_o, r.exp_ready);
    @(posedge clk_i);
    #1;
  endtask

  // Descriptor outputs against the oldest pending entry
  always @(negedge clk_i) begin
    if (rst_ni && desc_valid_o) begin
      if (exp_desc_q.size() == 0) begin
        errors++;
        $display("Unexpected descriptor with id %0h at %0d ns", desc_dma_id_o, $time);
      end else begin
        if (desc_dma_id_o !== exp_desc_q[0][71:64]) begin
          report_error("desc_dma_id_o", desc_dma_id_o, exp_desc_q[0][71:64]);
        end
        if (desc_remote_addr_o !== exp_desc_q[0][63:16]) begin
          report_error("desc_remote_addr_o", desc_remote_addr_o, exp_desc_q[0][63:16]);
        end
        if (desc_dma_len_o !== exp_desc_q[0][15:0]) begin
          report_error("desc_dma_len_o", desc_dma_len_o, exp_desc_q[0][15:0]);
        end
        // DUT pops on the coming edge
        if (desc_ready_i) begin
          void'(exp_desc_q.pop_front());
        end
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout, run still busy after %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_ni                  = 1'b0;
    cluster_base_addr_i     = ClusterBase;
    cfg_dma_id_i            = '0;
    cfg_dma_type_i          = 1'b0;
    cfg_reader_addr_i       = '0;
    cfg_writer_addr_i       = '0;
    cfg_frame_len_i         = '0;
    cfg_valid_i             = 1'b0;
    desc_ready_i            = 1'b1;
    rx_addr_i               = '0;
    rx_data_i               = '0;
    rx_valid_i              = 1'b0;
    from_remote_cfg_ready_i = 1'b1;
    seed                    = 32'h5386;
    errors                  = 0;
    cycle_cnt               = 0;
    build_table();
    cycle_limit = rows.size() * 40 + ResetCycles;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (desc_valid_o !== 1'b0) report_error("desc_valid_o after reset", desc_valid_o, 1'b0);
    if (grant_o !== 1'b0) report_error("grant_o after reset", grant_o, 1'b0);
    if (xdma_finish_o !== 1'b0) report_error("xdma_finish_o after reset", xdma_finish_o, 1'b0);
    if (from_remote_cfg_valid_o !== 1'b0) begin
      report_error("from_remote_cfg_valid_o after reset", from_remote_cfg_valid_o, 1'b0);
    end
    @(posedge clk_i);
    #1;
    foreach (rows[i]) begin
      case (rows[i].op)
        OP_TASK, OP_BODY: run_cfg_row(rows[i]);
        OP_RX:            run_rx_row(rows[i]);
        default:          run_hold_row(rows[i]);
      endcase
    end
    // Drain whatever is still queued
    desc_ready_i = 1'b1;
    while (exp_desc_q.size() != 0) @(posedge clk_i);
    @(negedge clk_i);
    if (desc_valid_o !== 1'b0) report_error("desc_valid_o after drain", desc_valid_o, 1'b0);
    $display("Rows run: %0d, errors: %0d", rows.size(), errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
+incdir+verif
design/xdma_pkg.sv
design/xdma_desc_if.sv
design/xdma_rx_if.sv
design/xdma_cfg_decode.sv
design/xdma_desc_issue.sv
design/xdma_rx_decode.sv
design/xdma_grant_tracker.sv
design/xdma_mailbox_top.sv
verif/xdma_mailbox_tb.sv
